// ==== csr_counter_if.sv ====
// counter port between the CSR register file and the counter block
// the register file drives a one-half write, the counters return both
// 64-bit values; a write lands at the next edge in place of the increment
`timescale 1ns/1ps

interface csr_counter_if import csr_pkg::*; ();

   logic        cnt_wr_en;
   cnt_sel_e    cnt_sel;
   logic [31:0] cnt_wdata;
   logic [63:0] mcycle;
   logic [63:0] minstret;

   modport regfile (
      output cnt_wr_en,
      output cnt_sel,
      output cnt_wdata,
      input  mcycle,
      input  minstret
   );

   modport counters (
      input  cnt_wr_en,
      input  cnt_sel,
      input  cnt_wdata,
      output mcycle,
      output minstret
   );

endinterface

// ==== csr_counters.sv ====
// 64-bit mcycle and minstret counters for the CSR unit
// mcycle steps every clock, minstret on every committed slot
// software writes one 32-bit half through the counter port; such a write
// replaces that cycle's increment of the counter it targets
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; (
   input  logic            clk,
   input  logic            resetb,
   input  logic            bubble,
   csr_counter_if.counters cnt
);

   logic [63:0] mcycle;
   logic [63:0] minstret;
   logic [63:0] mcycle_inc;
   logic [63:0] minstret_inc;

   assign mcycle_inc   = mcycle + 64'd1;
   assign minstret_inc = minstret + 64'd1;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         mcycle   <= 64'd0;
         minstret <= 64'd0;
      end else begin
         // free running unless software loads a half
         if (cnt.cnt_wr_en && cnt.cnt_sel == CNT_CYCLE_LO) begin
            mcycle <= {mcycle[63:32], cnt.cnt_wdata};
         end else if (cnt.cnt_wr_en && cnt.cnt_sel == CNT_CYCLE_HI) begin
            mcycle <= {cnt.cnt_wdata, mcycle[31:0]};
         end else begin
            mcycle <= mcycle_inc;
         end

         // retired count steps only on committed slots
         if (cnt.cnt_wr_en && cnt.cnt_sel == CNT_INSTRET_LO) begin
            minstret <= {minstret[63:32], cnt.cnt_wdata};
         end else if (cnt.cnt_wr_en && cnt.cnt_sel == CNT_INSTRET_HI) begin
            minstret <= {cnt.cnt_wdata, minstret[31:0]};
         end else if (!bubble) begin
            minstret <= minstret_inc;
         end
      end
   end

   assign cnt.mcycle   = mcycle;
   assign cnt.minstret = minstret;

   // software writes only come from committed slots
   assert property (@(posedge clk) disable iff (!resetb)
      cnt.cnt_wr_en |-> !bubble);

endmodule

// ==== csr_pkg.sv ====
// shared definitions for the machine-mode CSR unit
// holds the standard CSR addresses, the trap cause codes, the CSR address
// union and the counter-half select used on the counter write port
// blocks that need any of these take them with import csr_pkg::*
package csr_pkg;

   // identity registers, read only
   localparam logic [11:0] CSR_MVENDORID = 12'hF11;
   localparam logic [11:0] CSR_MARCHID   = 12'hF12;
   localparam logic [11:0] CSR_MIMPID    = 12'hF13;
   localparam logic [11:0] CSR_MHARTID   = 12'hF14;

   // machine trap setup and handling
   localparam logic [11:0] CSR_MISA      = 12'h301;
   localparam logic [11:0] CSR_MTVEC     = 12'h305;
   localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
   localparam logic [11:0] CSR_MEPC      = 12'h341;
   localparam logic [11:0] CSR_MCAUSE    = 12'h342;
   localparam logic [11:0] CSR_MTVAL     = 12'h343;

   // machine counters, low then high halves
   localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
   localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
   localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
   localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

   // MXL = 1 in bits 31:30, base integer ISA is bit 8
   localparam logic [31:0] MISA_RV32I = 32'h4000_0100;

   // synchronous exception codes written to mcause
   typedef enum logic [31:0] {
      CAUSE_INSTR_MISALIGNED = 32'd0,
      CAUSE_ILLEGAL_INSTR    = 32'd2,
      CAUSE_LOAD_MISALIGNED  = 32'd4,
      CAUSE_STORE_MISALIGNED = 32'd6
   } cause_e;

   // which counter half a software write lands in
   typedef enum logic [1:0] {
      CNT_CYCLE_LO   = 2'd0,
      CNT_CYCLE_HI   = 2'd1,
      CNT_INSTRET_LO = 2'd2,
      CNT_INSTRET_HI = 2'd3
   } cnt_sel_e;

   // one 12-bit address seen two ways
   // fields follow the privileged spec convention, groups split off the
   // low nibble so whole 16-entry blocks can be matched at once
   typedef union packed {
      struct packed {
         logic [1:0] access;   // 2'b11 marks read-only space
         logic [1:0] priv;
         logic [7:0] index;
      } fields;
      struct packed {
         logic [7:0] group;
         logic [3:0] low;
      } groups;
   } csr_addr_u;

endpackage

// ==== csr_regfile.sv ====
// CSR register file for the machine-mode CSR unit
// decodes the CSR address, runs read/write/set/clear on the writable
// registers, forwards counter writes to the counter block and returns the
// read value one edge after a committed read slot
// unknown addresses outside the performance-monitor groups are reported
// to the trap controller as a registered one-cycle pulse
`timescale 1ns/1ps

module csr_regfile import csr_pkg::*; #(
   parameter logic [31:0] HART_ID = 32'd0
) (
   input  logic           clk,
   input  logic           resetb,
   input  logic           bubble,
   input  logic           csr_read,
   input  logic           csr_write,
   input  logic           csr_set,
   input  logic           csr_clear,
   input  logic           csr_imm,
   input  logic [4:0]     rd_addr,
   input  logic [11:0]    csr_addr,
   input  logic [31:0]    rs1_data,
   input  logic [4:0]     uimm,
   output logic [31:0]    csr_rdata,
   output logic [31:0]    mepc_out,
   csr_counter_if.regfile cnt,
   csr_trap_if.regfile    trap
);

   csr_addr_u   addr;
   logic [31:0] operand;
   logic        do_read;
   logic        do_write;
   logic        do_set;
   logic        do_clear;
   logic        do_modify;
   logic        writable;
   logic        perf_group;
   logic        known;
   logic        cnt_hit;
   cnt_sel_e    cnt_sel;
   logic [31:0] cur_val;
   logic [31:0] new_val;
   logic [31:0] mscratch;
   logic [31:0] mepc;
   logic [31:0] mcause;
   logic [31:0] mtval;

   assign addr    = csr_addr;
   assign operand = csr_imm ? {27'd0, uimm} : rs1_data;

   // x0 destination and zero sources make the access side-effect free
   // uimm doubles as the rs1 index in the register form
   assign do_read   = !bubble && csr_read && (rd_addr != 5'd0);
   assign do_write  = !bubble && csr_write && !(csr_imm && uimm == 5'd0);
   assign do_set    = !bubble && csr_set && (uimm != 5'd0);
   assign do_clear  = !bubble && csr_clear && (uimm != 5'd0);
   assign writable  = (addr.fields.access != 2'b11);
   assign do_modify = (do_write || do_set || do_clear) && writable;

   assign perf_group = addr.groups.group inside
                       {8'hB0, 8'hB1, 8'hB8, 8'hB9, 8'h32, 8'h33};

   // read mux and counter target
   always_comb begin
      known   = 1'b1;
      cnt_hit = 1'b0;
      cnt_sel = CNT_CYCLE_LO;
      cur_val = 32'd0;
      case (csr_addr)
         CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID: cur_val = 32'd0;
         CSR_MHARTID:  cur_val = HART_ID;
         CSR_MISA:     cur_val = MISA_RV32I;
         CSR_MTVEC:    cur_val = 32'd0;   // direct mode, base 0
         CSR_MSCRATCH: cur_val = mscratch;
         CSR_MEPC:     cur_val = mepc;
         CSR_MCAUSE:   cur_val = mcause;
         CSR_MTVAL:    cur_val = mtval;
         CSR_MCYCLE: begin
            cur_val = cnt.mcycle[31:0];
            cnt_hit = 1'b1;
            cnt_sel = CNT_CYCLE_LO;
         end
         CSR_MCYCLEH: begin
            cur_val = cnt.mcycle[63:32];
            cnt_hit = 1'b1;
            cnt_sel = CNT_CYCLE_HI;
         end
         CSR_MINSTRET: begin
            cur_val = cnt.minstret[31:0];
            cnt_hit = 1'b1;
            cnt_sel = CNT_INSTRET_LO;
         end
         CSR_MINSTRETH: begin
            cur_val = cnt.minstret[63:32];
            cnt_hit = 1'b1;
            cnt_sel = CNT_INSTRET_HI;
         end
         default: begin
            // hpm counters and events read as zero, the rest is illegal
            known = perf_group;
         end
      endcase
   end

   always_comb begin
      if (do_write) begin
         new_val = operand;
      end else if (do_set) begin
         new_val = cur_val | operand;
      end else begin
         new_val = cur_val & ~operand;
      end
   end

   assign cnt.cnt_wr_en = do_modify && cnt_hit;
   assign cnt.cnt_sel   = cnt_sel;
   assign cnt.cnt_wdata = new_val;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         mscratch            <= 32'd0;
         mepc                <= 32'd0;
         mcause              <= 32'd0;
         mtval               <= 32'd0;
         csr_rdata           <= 32'd0;
         trap.illegal_access <= 1'b0;
      end else begin
         trap.illegal_access <= !bubble && !known &&
                                (csr_read || csr_write || csr_set || csr_clear);
         if (do_read) begin
            csr_rdata <= cur_val;
         end
         if (do_modify && csr_addr == CSR_MSCRATCH) begin
            mscratch <= new_val;
         end
         if (do_modify && csr_addr == CSR_MTVAL) begin
            mtval <= new_val;
         end
         if (do_modify && csr_addr == CSR_MEPC) begin
            mepc <= new_val;
         end
         if (do_modify && csr_addr == CSR_MCAUSE) begin
            mcause <= new_val;
         end
         // trap entry wins over a software write in the same cycle
         if (trap.trap_take) begin
            mepc   <= trap.trap_pc;
            mcause <= trap.trap_cause;
         end
      end
   end

   assign mepc_out = mepc;

   // the decoder only ever sees one modify operation per slot
   assert property (@(posedge clk) disable iff (!resetb)
      !bubble |-> $onehot0({csr_write, csr_set, csr_clear}));

endmodule

// ==== csr_trap_ctrl.sv ====
// trap controller for the machine-mode CSR unit
// turns committed front-end exceptions into same-cycle trap requests and
// picks the cause by priority; a late illegal-CSR report from the register
// file traps one cycle after the faulting slot, using that slot's pc
`timescale 1ns/1ps

module csr_trap_ctrl import csr_pkg::*; (
   input  logic        clk,
   input  logic        resetb,
   input  logic        bubble,
   input  logic        exc_unsupported,
   input  logic        exc_illegal,
   input  logic        exc_instr_misaligned,
   input  logic        exc_load_misaligned,
   input  logic        exc_store_misaligned,
   input  logic [31:0] fetch_pc,
   input  logic [31:0] commit_pc,
   output logic        initiate_illinst,
   output logic        initiate_misaligned,
   csr_trap_if.ctrl    trap
);

   localparam logic RUN       = 1'b0;
   localparam logic CSR_FAULT = 1'b1;

   logic        state;
   logic        state_nxt;
   logic        fe_any;
   cause_e      fe_cause;
   logic [31:0] fault_pc;

   assign fe_any = exc_unsupported | exc_illegal | exc_instr_misaligned |
                   exc_load_misaligned | exc_store_misaligned;

   // fetch fault first, then decode, then the memory stage faults
   always_comb begin
      if (exc_instr_misaligned) begin
         fe_cause = CAUSE_INSTR_MISALIGNED;
      end else if (exc_illegal || exc_unsupported) begin
         fe_cause = CAUSE_ILLEGAL_INSTR;
      end else if (exc_load_misaligned) begin
         fe_cause = CAUSE_LOAD_MISALIGNED;
      end else begin
         fe_cause = CAUSE_STORE_MISALIGNED;
      end
   end

   // pc of the last committed slot, the one a CSR fault points back to
   always_ff @(posedge clk) begin
      if (!bubble) begin
         fault_pc <= commit_pc;
      end
   end

   always_comb begin
      state_nxt           = RUN;
      trap.trap_take      = 1'b0;
      trap.trap_cause     = fe_cause;
      trap.trap_pc        = fetch_pc;
      initiate_illinst    = 1'b0;
      initiate_misaligned = 1'b0;
      // in CSR_FAULT the slot behind the trapping access is being flushed,
      // so a second report right after is not a new fault
      if (trap.illegal_access && state == RUN) begin
         state_nxt        = CSR_FAULT;
         trap.trap_take   = 1'b1;
         trap.trap_cause  = CAUSE_ILLEGAL_INSTR;
         trap.trap_pc     = fault_pc;
         initiate_illinst = 1'b1;
      end else if (!bubble && fe_any) begin
         trap.trap_take      = 1'b1;
         initiate_illinst    = (fe_cause == CAUSE_ILLEGAL_INSTR);
         initiate_misaligned = (fe_cause != CAUSE_ILLEGAL_INSTR);
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         state <= RUN;
      end else begin
         state <= state_nxt;
      end
   end

   // a CSR fault report always points back at a committed slot
   assert property (@(posedge clk) disable iff (!resetb)
      trap.illegal_access |-> $past(!bubble));

endmodule

// ==== csr_trap_if.sv ====
// trap port between the trap controller and the CSR register file
// illegal_access is a registered pulse from the register file; trap_take
// with its cause and pc is loaded into mcause and mepc at the next edge
`timescale 1ns/1ps

interface csr_trap_if import csr_pkg::*; ();

   logic        illegal_access;
   logic        trap_take;
   cause_e      trap_cause;
   logic [31:0] trap_pc;

   modport regfile (
      output illegal_access,
      input  trap_take,
      input  trap_cause,
      input  trap_pc
   );

   modport ctrl (
      input  illegal_access,
      output trap_take,
      output trap_cause,
      output trap_pc
   );

endinterface

// ==== csr_unit.sv ====
// machine-mode CSR unit at the execute/writeback boundary of a small
// RV32 core; one instruction slot per cycle, qualified by bubble
// ties together the trap controller, the counters and the register file
// HART_ID is the value returned by mhartid
`timescale 1ns/1ps

module csr_unit #(
   parameter logic [31:0] HART_ID = 32'd0
) (
   input  logic        clk,
   input  logic        resetb,
   input  logic        bubble,
   input  logic        csr_read,
   input  logic        csr_write,
   input  logic        csr_set,
   input  logic        csr_clear,
   input  logic        csr_imm,
   input  logic [4:0]  rd_addr,
   input  logic [11:0] csr_addr,
   input  logic [31:0] rs1_data,
   input  logic [4:0]  uimm,
   input  logic [31:0] fetch_pc,
   input  logic [31:0] commit_pc,
   input  logic        exc_unsupported,
   input  logic        exc_illegal,
   input  logic        exc_instr_misaligned,
   input  logic        exc_load_misaligned,
   input  logic        exc_store_misaligned,
   output logic [31:0] csr_rdata,
   output logic        initiate_illinst,
   output logic        initiate_misaligned,
   output logic [31:0] mepc_out
);

   csr_counter_if cnt_if ();
   csr_trap_if    trap_if ();

   csr_trap_ctrl u_trap_ctrl (
      .clk                  (clk),
      .resetb               (resetb),
      .bubble               (bubble),
      .exc_unsupported      (exc_unsupported),
      .exc_illegal          (exc_illegal),
      .exc_instr_misaligned (exc_instr_misaligned),
      .exc_load_misaligned  (exc_load_misaligned),
      .exc_store_misaligned (exc_store_misaligned),
      .fetch_pc             (fetch_pc),
      .commit_pc            (commit_pc),
      .initiate_illinst     (initiate_illinst),
      .initiate_misaligned  (initiate_misaligned),
      .trap                 (trap_if.ctrl)
   );

   csr_counters u_counters (
      .clk    (clk),
      .resetb (resetb),
      .bubble (bubble),
      .cnt    (cnt_if.counters)
   );

   csr_regfile #(
      .HART_ID (HART_ID)
   ) u_regfile (
      .clk       (clk),
      .resetb    (resetb),
      .bubble    (bubble),
      .csr_read  (csr_read),
      .csr_write (csr_write),
      .csr_set   (csr_set),
      .csr_clear (csr_clear),
      .csr_imm   (csr_imm),
      .rd_addr   (rd_addr),
      .csr_addr  (csr_addr),
      .rs1_data  (rs1_data),
      .uimm      (uimm),
      .csr_rdata (csr_rdata),
      .mepc_out  (mepc_out),
      .cnt       (cnt_if.regfile),
      .trap      (trap_if.regfile)
   );

endmodule

// ==== csr_unit_tb.sv ====
// directed testbench for the machine-mode CSR unit
// each test is a task that drives instruction slots on the falling edge and
// checks csr_rdata, mepc_out and the initiate outputs against values
// predicted from the CSR rules; a cycle counter bounds the whole run
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

   localparam logic [31:0] TB_HART_ID = 32'd5;
   localparam int OP_W = 0;
   localparam int OP_S = 1;
   localparam int OP_C = 2;

   // slots per test, upper bounds
   localparam int LEN_RESET    = 6;
   localparam int LEN_IDENTITY = 16;
   localparam int LEN_SCRATCH  = 60;
   localparam int LEN_COUNTERS = 33;
   localparam int LEN_FRONTEND = 42;
   localparam int LEN_ILLEGAL  = 20;
   localparam int CYCLE_LIMIT  = LEN_RESET + LEN_IDENTITY + LEN_SCRATCH + LEN_COUNTERS +
                                 LEN_FRONTEND + LEN_ILLEGAL + 50;

   logic        clk;
   logic        resetb;
   logic        bubble;
   logic        csr_read;
   logic        csr_write;
   logic        csr_set;
   logic        csr_clear;
   logic        csr_imm;
   logic [4:0]  rd_addr;
   logic [11:0] csr_addr;
   logic [31:0] rs1_data;
   logic [4:0]  uimm;
   logic [31:0] fetch_pc;
   logic [31:0] commit_pc;
   logic        exc_unsupported;
   logic        exc_illegal;
   logic        exc_instr_misaligned;
   logic        exc_load_misaligned;
   logic        exc_store_misaligned;
   logic [31:0] csr_rdata;
   logic        initiate_illinst;
   logic        initiate_misaligned;
   logic [31:0] mepc_out;

   int          check_count;
   int          error_count;
   int          cycle_count;
   integer      seed;

   tb_clock_gen #(
      .PERIOD_NS    (8.0),
      .RESET_CYCLES (5)
   ) u_clock_gen (
      .clk    (clk),
      .resetb (resetb)
   );

   csr_unit #(
      .HART_ID (TB_HART_ID)
   ) UUT (
      .clk                  (clk),
      .resetb               (resetb),
      .bubble               (bubble),
      .csr_read             (csr_read),
      .csr_write            (csr_write),
      .csr_set              (csr_set),
      .csr_clear            (csr_clear),
      .csr_imm              (csr_imm),
      .rd_addr              (rd_addr),
      .csr_addr             (csr_addr),
      .rs1_data             (rs1_data),
      .uimm                 (uimm),
      .fetch_pc             (fetch_pc),
      .commit_pc            (commit_pc),
      .exc_unsupported      (exc_unsupported),
      .exc_illegal          (exc_illegal),
      .exc_instr_misaligned (exc_instr_misaligned),
      .exc_load_misaligned  (exc_load_misaligned),
      .exc_store_misaligned (exc_store_misaligned),
      .csr_rdata            (csr_rdata),
      .initiate_illinst     (initiate_illinst),
      .initiate_misaligned  (initiate_misaligned),
      .mepc_out             (mepc_out)
   );

   task automatic compare_word(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic compare_cause(input string name, input cause_e exp, input cause_e act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("MISMATCH %s expected cause %0d actual cause %0d", name, exp, act);
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("MISMATCH %s expected %0b actual %0b", name, exp, act);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-10s %s", name, (error_count == errs_before) ? "ok" : "FAILED");
   endtask

   // one slot, driven on the falling edge, front-end flags cleared
   task automatic issue_slot(input logic bub, input logic rd, input logic wr,
                             input logic st, input logic cl, input logic imm,
                             input logic [4:0] rd_a, input logic [11:0] addr,
                             input logic [31:0] rs1, input logic [4:0] u);
      @(negedge clk);
      bubble               = bub;
      csr_read             = rd;
      csr_write            = wr;
      csr_set              = st;
      csr_clear            = cl;
      csr_imm              = imm;
      rd_addr              = rd_a;
      csr_addr             = addr;
      rs1_data             = rs1;
      uimm                 = u;
      exc_unsupported      = 1'b0;
      exc_illegal          = 1'b0;
      exc_instr_misaligned = 1'b0;
      exc_load_misaligned  = 1'b0;
      exc_store_misaligned = 1'b0;
   endtask

   task automatic idle_slot();
      issue_slot(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 12'h000, 32'd0, 5'd0);
   endtask

   // read slot then an idle slot, value sampled once it is registered
   task automatic read_csr(input logic [11:0] addr, output logic [31:0] val);
      issue_slot(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd1, addr, 32'd0, 5'd0);
      idle_slot();
      val = csr_rdata;
   endtask

   task automatic csr_modify(input int op, input logic imm, input logic [11:0] addr,
                             input logic [31:0] rs1, input logic [4:0] u);
      issue_slot(1'b0, 1'b0, op == OP_W, op == OP_S, op == OP_C, imm, 5'd0, addr, rs1, u);
   endtask

   task automatic drive_exception(input logic bub, input logic [4:0] flags,
                                  input logic [31:0] pc);
      idle_slot();
      bubble   = bub;
      fetch_pc = pc;
      {exc_instr_misaligned, exc_illegal, exc_unsupported,
       exc_load_misaligned, exc_store_misaligned} = flags;
   endtask

   // expected register value after a write, set or clear
   function automatic logic [31:0] model_op(input int op, input logic imm,
                                            input logic [31:0] old,
                                            input logic [31:0] rs1, input logic [4:0] u);
      logic [31:0] src;
      src = imm ? {27'd0, u} : rs1;
      if (op == OP_W) begin
         return (imm && u == 5'd0) ? old : src;
      end
      if (u == 5'd0) begin
         return old;
      end
      if (op == OP_S) begin
         return old | src;
      end
      return old & ~src;
   endfunction

   task automatic modify_and_check(input string name, input logic [11:0] addr,
                                   input int op, input logic imm, input logic [31:0] rs1,
                                   input logic [4:0] u, inout logic [31:0] model);
      logic [31:0] got;
      csr_modify(op, imm, addr, rs1, u);
      model = model_op(op, imm, model, rs1, u);
      read_csr(addr, got);
      compare_word(name, model, got);
   endtask

   task automatic test_identity();
      logic [11:0] zero_regs [4];
      logic [31:0] got;
      int          errs;
      errs      = error_count;
      zero_regs = '{CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MTVEC};
      read_csr(CSR_MISA, got);
      compare_word("identity misa", MISA_RV32I, got);
      read_csr(CSR_MHARTID, got);
      compare_word("identity mhartid", TB_HART_ID, got);
      foreach (zero_regs[i]) begin
         read_csr(zero_regs[i], got);
         #1;
         compare_word("identity zero reg", 32'd0, got);
         compare_flag("identity no trap", 1'b0, initiate_illinst);
      end
      // x0 destination keeps the earlier read value
      read_csr(CSR_MISA, got);
      issue_slot(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, CSR_MHARTID, 32'd0, 5'd0);
      idle_slot();
      compare_word("identity rd x0", MISA_RV32I, csr_rdata);
      report_test("identity", errs);
   endtask

   task automatic test_scratch(input string tname, input logic [11:0] addr);
      logic [31:0] model;
      logic [4:0]  u;
      int          errs;
      errs  = error_count;
      model = 32'd0;
      modify_and_check({tname, " write"}, addr, OP_W, 1'b0, $random(seed), 5'd3, model);
      modify_and_check({tname, " set"}, addr, OP_S, 1'b0, $random(seed), 5'd3, model);
      modify_and_check({tname, " clear"}, addr, OP_C, 1'b0, $random(seed), 5'd3, model);
      u    = $random(seed);
      u[0] = 1'b1;
      modify_and_check({tname, " writei"}, addr, OP_W, 1'b1, $random(seed), u, model);
      u    = $random(seed);
      u[1] = 1'b1;
      modify_and_check({tname, " seti"}, addr, OP_S, 1'b1, $random(seed), u, model);
      u    = $random(seed);
      u[0] = 1'b1;
      modify_and_check({tname, " cleari"}, addr, OP_C, 1'b1, $random(seed), u, model);
      modify_and_check({tname, " refill"}, addr, OP_W, 1'b0, $random(seed), 5'd7, model);
      // zero sources leave the register alone
      modify_and_check({tname, " writei 0"}, addr, OP_W, 1'b1, $random(seed), 5'd0, model);
      modify_and_check({tname, " set x0"}, addr, OP_S, 1'b0, $random(seed), 5'd0, model);
      modify_and_check({tname, " clear x0"}, addr, OP_C, 1'b0, 32'hFFFF_FFFF, 5'd0, model);
      report_test(tname, errs);
   endtask

   task automatic test_counters();
      logic [31:0] wval;
      logic [31:0] hval;
      logic [31:0] first;
      logic [31:0] got;
      logic        bub;
      int          n;
      int          committed;
      int          errs;
      errs = error_count;
      // mcycle steps once per slot after the write lands
      wval = $random(seed) & 32'h0FFF_FFFF;
      n    = 3 + ($random(seed) & 7);
      csr_modify(OP_W, 1'b0, CSR_MCYCLE, wval, 5'd3);
      repeat (n) idle_slot();
      read_csr(CSR_MCYCLE, got);
      compare_word("counters mcycle", wval + n, got);
      read_csr(CSR_MINSTRET, first);
      committed = 0;
      repeat (12) begin
         bub = $random(seed);
         issue_slot(bub, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 12'h000, 32'd0, 5'd0);
         if (!bub) begin
            committed++;
         end
      end
      read_csr(CSR_MINSTRET, got);
      // the first read slot retires as well
      compare_word("counters minstret", first + 1 + committed, got);
      hval = $random(seed);
      csr_modify(OP_W, 1'b0, CSR_MCYCLE, 32'd0, 5'd3);
      csr_modify(OP_W, 1'b0, CSR_MCYCLEH, hval, 5'd3);
      read_csr(CSR_MCYCLEH, got);
      compare_word("counters mcycleh", hval, got);
      report_test("counters", errs);
   endtask

   // flags are {instr, illegal, unsupported, load, store}
   task automatic frontend_case(input string name, input logic [4:0] flags,
                                input cause_e cause, input logic ill, input logic mis);
      logic [31:0] pc;
      logic [31:0] got;
      pc      = $random(seed);
      pc[1:0] = 2'b00;
      drive_exception(1'b0, flags, pc);
      #1;
      compare_flag({name, " illinst"}, ill, initiate_illinst);
      compare_flag({name, " misaligned"}, mis, initiate_misaligned);
      idle_slot();
      compare_word({name, " mepc"}, pc, mepc_out);
      read_csr(CSR_MCAUSE, got);
      compare_cause({name, " mcause"}, cause, cause_e'(got));
   endtask

   task automatic test_frontend();
      logic [31:0] old_cause;
      logic [31:0] old_pc;
      logic [31:0] got;
      int          errs;
      errs = error_count;
      frontend_case("fe instr", 5'b10000, CAUSE_INSTR_MISALIGNED, 1'b0, 1'b1);
      frontend_case("fe illegal", 5'b01000, CAUSE_ILLEGAL_INSTR, 1'b1, 1'b0);
      frontend_case("fe unsupported", 5'b00100, CAUSE_ILLEGAL_INSTR, 1'b1, 1'b0);
      frontend_case("fe load", 5'b00010, CAUSE_LOAD_MISALIGNED, 1'b0, 1'b1);
      frontend_case("fe store", 5'b00001, CAUSE_STORE_MISALIGNED, 1'b0, 1'b1);
      frontend_case("fe instr+load", 5'b10010, CAUSE_INSTR_MISALIGNED, 1'b0, 1'b1);
      frontend_case("fe illegal+store", 5'b01011, CAUSE_ILLEGAL_INSTR, 1'b1, 1'b0);
      frontend_case("fe all", 5'b11111, CAUSE_INSTR_MISALIGNED, 1'b0, 1'b1);
      frontend_case("fe load+store", 5'b00011, CAUSE_LOAD_MISALIGNED, 0, 1);
      // a bubble slot carries no exception
      read_csr(CSR_MCAUSE, old_cause);
      old_pc = mepc_out;
      drive_exception(1'b1, 5'b11111, 32'hDEAD_BEE0);
      #1;
      compare_flag("fe bubble illinst", 1'b0, initiate_illinst);
      compare_flag("fe bubble misaligned", 1'b0, initiate_misaligned);
      idle_slot();
      compare_word("fe bubble mepc", old_pc, mepc_out);
      read_csr(CSR_MCAUSE, got);
      compare_cause("fe bubble mcause", cause_e'(old_cause), cause_e'(got));
      report_test("frontend", errs);
   endtask

   task automatic test_illegal();
      logic [11:0] perf_addrs [6];
      logic [31:0] pc;
      logic [31:0] got;
      int          errs;
      errs       = error_count;
      perf_addrs = '{12'hB03, 12'hB1F, 12'hB83, 12'hB9F, 12'h323, 12'h33F};
      pc         = $random(seed);
      pc[1:0]    = 2'b00;
      issue_slot(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd1, 12'h7C0, 32'd0, 5'd0);
      commit_pc = pc;
      #1;
      compare_flag("illegal same cycle", 1'b0, initiate_illinst);
      // the slot after is a bubble and the fault still fires
      idle_slot();
      #1;
      compare_flag("illegal next cycle", 1'b1, initiate_illinst);
      compare_flag("illegal misaligned", 1'b0, initiate_misaligned);
      idle_slot();
      #1;
      compare_flag("illegal pulse end", 1'b0, initiate_illinst);
      compare_word("illegal mepc", pc, mepc_out);
      read_csr(CSR_MCAUSE, got);
      compare_cause("illegal mcause", CAUSE_ILLEGAL_INSTR, cause_e'(got));
      issue_slot(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd1, 12'h7C0, 32'd0, 5'd0);
      commit_pc = pc ^ 32'h0000_1000;
      idle_slot();
      #1;
      compare_flag("illegal bubble", 1'b0, initiate_illinst);
      idle_slot();
      compare_word("illegal bubble mepc", pc, mepc_out);
      foreach (perf_addrs[i]) begin
         read_csr(perf_addrs[i], got);
         #1;
         compare_word("illegal perf read", 32'd0, got);
         compare_flag("illegal perf no trap", 1'b0, initiate_illinst);
      end
      report_test("illegal", errs);
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, tests did not complete", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
   end

   initial begin
      seed                 = 32'h3270;
      check_count          = 0;
      error_count          = 0;
      bubble               = 1'b1;
      csr_read             = 1'b0;
      csr_write            = 1'b0;
      csr_set              = 1'b0;
      csr_clear            = 1'b0;
      csr_imm              = 1'b0;
      rd_addr              = 5'd0;
      csr_addr             = 12'h000;
      rs1_data             = 32'd0;
      uimm                 = 5'd0;
      fetch_pc             = 32'd0;
      commit_pc            = 32'd0;
      exc_unsupported      = 1'b0;
      exc_illegal          = 1'b0;
      exc_instr_misaligned = 1'b0;
      exc_load_misaligned  = 1'b0;
      exc_store_misaligned = 1'b0;
      @(posedge resetb);
      test_identity();
      test_scratch("mscratch", CSR_MSCRATCH);
      test_scratch("mtval", CSR_MTVAL);
      test_counters();
      test_frontend();
      test_illegal();
      @(negedge clk);
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
csr_pkg.sv
csr_counter_if.sv
csr_trap_if.sv
csr_trap_ctrl.sv
csr_counters.sv
csr_regfile.sv
csr_unit.sv
tb_clock_gen.sv
csr_unit_tb.sv

// ==== tb_clock_gen.sv ====
// clock and reset source for the CSR unit testbench
// free-running clock of PERIOD_NS, resetb held low for RESET_CYCLES
// rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS    = 8.0,
   parameter int  RESET_CYCLES = 5
) (
   output logic clk,
   output logic resetb
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   // release away from the rising edge
   initial begin
      resetb = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
   end

endmodule
